// File: src/video_defines.svh
`ifndef VIDEO_DEFINES_SVH
`define VIDEO_DEFINES_SVH

// raster geometry
`define LINE_PIXELS 64
`define VISIBLE_LINES 16
`define VBLANK_LINES 4
`define FRAME_LINES (`VISIBLE_LINES + `VBLANK_LINES)

// video line memory, 64 words of 64 bits
`define VRAM_AW 6
`define VRAM_DW 64

// font memory, symbol code in the high 8 bits, row in the low 3
`define FONT_AW 11
`define FONT_DW 8

// flash counter width, top bit is the flash level
`define FLASH_BITS 5

// pixel slots per fetch block
`define BLOCK_SHORT 16
`define BLOCK_LONG 32

`endif

// File: src/video_pkg.sv
package video_pkg;

	// rendering modes as seen on the mode input
	typedef enum logic [2:0]
	{
		mode_zx      = 3'd0,
		mode_p_16c   = 3'd1,
		mode_p_hmclr = 3'd2,
		mode_a_hmclr = 3'd3,
		mode_a_16c   = 3'd4,
		mode_a_text  = 3'd5
	} video_mode_e;

	// raster sequencer states
	typedef enum logic [1:0]
	{
		st_idle   = 2'd0, // settling after reset
		st_active = 2'd1, // visible lines
		st_vblank = 2'd2  // blank lines at frame end
	} seq_state_e;

endpackage

// File: src/video_sync.sv
`timescale 1ns/1ns
`include "video_defines.svh"

module video_sync
	import video_pkg::*;
(
	input  logic        clk,
	input  logic        arst_n,
	input  video_mode_e mode,
	input  logic        pixf_14,
	output logic        c0,
	output logic        c1,
	output logic        c2,
	output logic        c3,
	output logic        pix_stb,
	output logic        fetch_sync,
	output logic        line_start,
	output logic        int_start,
	output logic [2:0]  typos
);

	localparam int SLOT_W = $clog2(`LINE_PIXELS);
	localparam int LINE_W = $clog2(`FRAME_LINES);

	seq_state_e        state;
	logic [1:0]        phase;     // position in the c rotation
	logic [SLOT_W-1:0] slot;      // pixel slots done in this line
	logic [LINE_W-1:0] line;
	logic              running;
	logic              active;
	logic              ena_pix;   // pixel slot, also counted in vblank
	logic              slot_last;
	logic              blk_short;
	logic              blk_start;

	assign running = (state != st_idle);
	assign active  = (state == st_active);

	assign c0 = running & (phase == 2'd0);
	assign c1 = running & (phase == 2'd1);
	assign c2 = running & (phase == 2'd2);
	assign c3 = running & (phase == 2'd3);

	assign ena_pix   = c3 | (pixf_14 & c1);
	assign slot_last = (slot == SLOT_W'(`LINE_PIXELS - 1));

	assign blk_short = (mode == mode_zx) || (mode == mode_p_16c) || (mode == mode_a_16c);
	assign blk_start = blk_short ? (slot[3:0] == 4'd0) : (slot[4:0] == 5'd0);

	assign pix_stb    = ena_pix & active;
	assign fetch_sync = c0 & active & blk_start;
	assign line_start = c0 & active & (slot == '0);
	assign int_start  = line_start & (line == '0);
	assign typos      = line[2:0];

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
			phase <= 2'd0;
		else
			phase <= phase + 2'd1;

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
		begin
			slot <= '0;
			line <= '0;
		end
		else if (ena_pix)
		begin
			slot <= slot_last ? '0 : slot + 1'b1;
			if (slot_last)
				line <= (line == LINE_W'(`FRAME_LINES - 1)) ? '0 : line + 1'b1;
		end

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
			state <= st_idle;
		else
			case (state)
				st_idle:
					if (phase == 2'd3)
						state <= st_active; // one full rotation waited
				st_active:
					if (ena_pix && slot_last && line == LINE_W'(`VISIBLE_LINES - 1))
						state <= st_vblank;
				st_vblank:
					if (ena_pix && slot_last && line == LINE_W'(`FRAME_LINES - 1))
						state <= st_active;
				default:
					state <= st_idle;
			endcase

	a_c_onehot: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0({c3, c2, c1, c0}));

	a_fetch_c0: assert property (@(posedge clk) disable iff (!arst_n)
		fetch_sync |-> c0);

endmodule

// File: src/video_fetch.sv
`timescale 1ns/1ns
`include "video_defines.svh"

module video_fetch
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic [`VRAM_AW-1:0] vram_a,
	input  logic [`VRAM_DW-1:0] vram_d,
	input  logic                vram_wr,
	input  logic                fetch_sync,
	input  logic                int_start,
	output logic [`VRAM_DW-1:0] pic_bits
);

	localparam int WORDS = 1 << `VRAM_AW;

	logic [`VRAM_DW-1:0] mem [0:WORDS-1];
	logic [`VRAM_AW-1:0] faddr;   // next word to fetch
	logic [`VRAM_AW-1:0] rd_addr;

	// frame start reads word 0 no matter where the counter stands
	assign rd_addr = int_start ? '0 : faddr;

	always_ff @(posedge clk)
		if (vram_wr)
			mem[vram_a] <= vram_d; // host port

	always_ff @(posedge clk)
		if (fetch_sync)
			pic_bits <= mem[rd_addr]; // valid from the cycle after the strobe

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
			faddr <= '0;
		else if (fetch_sync)
			faddr <= rd_addr + 1'b1; // wraps over the whole memory

	a_vram_a_known: assert property (@(posedge clk) disable iff (!arst_n)
		vram_wr |-> !$isunknown(vram_a));

	// the sequencer must open every frame with a fetch
	a_frame_fetch: assert property (@(posedge clk) disable iff (!arst_n)
		int_start |-> fetch_sync);

endmodule

// File: src/video_fontrom.sv
`timescale 1ns/1ns
`include "video_defines.svh"

module video_fontrom
(
	input  logic                clk,
	input  logic [`FONT_AW-1:0] wraddress,
	input  logic [`FONT_DW-1:0] data,
	input  logic                wren,
	input  logic [`FONT_AW-1:0] rdaddress,
	input  logic                rden,
	output logic [`FONT_DW-1:0] q
);

	localparam int DEPTH = 1 << `FONT_AW;

	logic [`FONT_DW-1:0] mem [0:DEPTH-1];

	always_ff @(posedge clk)
		if (wren)
			mem[wraddress] <= data;

	// q keeps the last glyph row while rden is low
	always_ff @(posedge clk)
		if (rden)
			q <= mem[rdaddress];

endmodule

// File: src/video_render.sv
`timescale 1ns/1ns
`include "video_defines.svh"

module video_render
	import video_pkg::*;
(
	input  logic                clk,
	input  logic                arst_n,
	input  logic [`VRAM_DW-1:0] pic_bits,
	input  logic                fetch_sync, // comes with c0
	input  logic                c1,
	input  logic                c3,
	input  logic                int_start,
	input  logic [2:0]          typos,      // row inside the symbol
	input  video_mode_e         mode,
	input  logic                pixf_14,
	input  logic [`FONT_AW-1:0] fnt_a,
	input  logic [`FONT_DW-1:0] fnt_d,
	input  logic                fnt_wr,
	output logic [3:0]          pixels
);

	logic [`FLASH_BITS-1:0] flash_ctr;
	logic                   flash;

	logic modes_16c;    // two pixels per byte
	logic modes_zxattr; // zx style attribute with flash
	logic mode_text;

	logic       ena_pix;
	logic [2:0] pnum;   // pixel inside the group
	logic [2:0] padd;
	logic [1:0] gnum;   // group inside the fetched word
	logic [1:0] gadd;
	logic       ginc;   // last slot of a group

	logic [7:0] bytes [0:7];
	logic [2:0] pix_idx;
	logic [2:0] attr_idx;
	logic [7:0] pixbyte;
	logic [7:0] attrbyte;
	logic [7:0] symbyte;
	logic [7:0] c16_byte;
	logic [3:0] c16pix;
	logic [3:0] pix0;   // paper
	logic [3:0] pix1;   // ink
	logic       pixbit;
	logic [3:0] apix;
	logic       rom_ena;

	always_comb
	begin
		modes_16c    = 1'b0;
		modes_zxattr = 1'b0;
		mode_text    = 1'b0;
		case (mode)
			mode_zx:      modes_zxattr = 1'b1;
			mode_p_hmclr: modes_zxattr = 1'b1;
			mode_p_16c:   modes_16c    = 1'b1;
			mode_a_16c:   modes_16c    = 1'b1;
			mode_a_text:  mode_text    = 1'b1;
			default:      ;             // ATM hi-colour uses the defaults
		endcase
	end

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
			flash_ctr <= '0;
		else if (int_start)
			flash_ctr <= flash_ctr + 1'b1;

	assign flash = flash_ctr[`FLASH_BITS-1];

	assign ena_pix = c3 | (pixf_14 & c1);

	assign {ginc, padd} = {1'b0, pnum} + {2'b00, modes_16c, ~modes_16c};
	assign gadd = gnum + ({modes_zxattr, ~modes_zxattr} & {2{ginc}});

	always_ff @(posedge clk or negedge arst_n)
		if (!arst_n)
		begin
			pnum <= '0;
			gnum <= '0;
		end
		else if (fetch_sync)
		begin
			pnum <= '0;
			gnum <= '0;
		end
		else if (ena_pix)
		begin
			pnum <= padd;
			gnum <= gadd;
		end

	always_comb
		for (int i = 0; i < 8; i++)
			bytes[i] = pic_bits[8*i +: 8];

	// interleaved byte order of the fetched word
	assign pix_idx  = {gnum[0], 1'b0, gnum[1]};
	assign attr_idx = {gnum[0], 1'b1, gnum[1]};
	assign pixbyte  = bytes[pix_idx];
	assign attrbyte = bytes[attr_idx];

	// attribute byte first, then pixel byte
	assign c16_byte = pnum[2] ? pixbyte : attrbyte;
	assign c16pix   = pnum[1] ? {c16_byte[7], c16_byte[5:3]} : {c16_byte[6], c16_byte[2:0]};

	assign pix0 = {(modes_zxattr ? attrbyte[6] : attrbyte[7]), attrbyte[5:3]};
	assign pix1 = {attrbyte[6], attrbyte[2:0]};

	assign pixbit = mode_text ? symbyte[~pnum] : pixbyte[~pnum]; // msb first
	assign apix   = (pixbit ^ (modes_zxattr & flash & attrbyte[7])) ? pix1 : pix0;

	assign pixels = modes_16c ? c16pix : apix;

	// glyph row fetched at the last slot, ready before the next one
	assign rom_ena = ena_pix & ginc;

	video_fontrom video_fontrom_inst
	(
		.clk       (clk),
		.wraddress (fnt_a),
		.data      (fnt_d),
		.wren      (fnt_wr),
		.rdaddress ({pixbyte, typos}),
		.rden      (rom_ena),
		.q         (symbyte)
	);

	a_pnum_even: assert property (@(posedge clk) disable iff (!arst_n)
		ena_pix && modes_16c |-> !pnum[0]);

endmodule

// File: src/video_top.sv
`timescale 1ns/1ns
`include "video_defines.svh"

module video_top
	import video_pkg::*;
(
	input  logic                clk,
	input  logic                arst_n,
	input  video_mode_e         mode,
	input  logic                pixf_14,  // double pixel rate
	input  logic [`VRAM_AW-1:0] vram_a,
	input  logic [`VRAM_DW-1:0] vram_d,
	input  logic                vram_wr,
	input  logic [`FONT_AW-1:0] fnt_a,
	input  logic [`FONT_DW-1:0] fnt_d,
	input  logic                fnt_wr,
	output logic [3:0]          pixels,
	output logic                pix_stb,
	output logic                line_start,
	output logic                int_start
);

	logic                c1;
	logic                c3;
	logic                fetch_sync;
	logic [2:0]          typos;
	logic [`VRAM_DW-1:0] pic_bits;

	video_sync video_sync_inst
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.mode       (mode),
		.pixf_14    (pixf_14),
		.c0         (),         // only watched from the testbench
		.c1         (c1),
		.c2         (),
		.c3         (c3),
		.pix_stb    (pix_stb),
		.fetch_sync (fetch_sync),
		.line_start (line_start),
		.int_start  (int_start),
		.typos      (typos)
	);

	video_fetch video_fetch_inst
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.vram_a     (vram_a),
		.vram_d     (vram_d),
		.vram_wr    (vram_wr),
		.fetch_sync (fetch_sync),
		.int_start  (int_start),
		.pic_bits   (pic_bits)
	);

	video_render video_render_inst
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.pic_bits   (pic_bits),
		.fetch_sync (fetch_sync),
		.c1         (c1),
		.c3         (c3),
		.int_start  (int_start),
		.typos      (typos),
		.mode       (mode),
		.pixf_14    (pixf_14),
		.fnt_a      (fnt_a),
		.fnt_d      (fnt_d),
		.fnt_wr     (fnt_wr),
		.pixels     (pixels)
	);

endmodule

// File: tests/tb_clock.sv
`timescale 1ns/1ns

module tb_clock
(
	output logic clk,
	output logic arst_n
);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial
	begin
		arst_n = 1'b0;
		#400 arst_n = 1'b1; // 4 cycles, released on a falling edge
	end

endmodule

// File: tests/video_tb.sv
`timescale 1ns/1ns
`include "video_defines.svh"

module video_tb
	import video_pkg::*;
();

	localparam int FRAME_CYCLES = `FRAME_LINES * `LINE_PIXELS * 4;
	localparam int WAIT_LIMIT   = 3 * FRAME_CYCLES;

	logic                clk;
	logic                arst_n;
	video_mode_e         mode;
	logic                pixf_14;
	logic [`VRAM_AW-1:0] vram_a;
	logic [`VRAM_DW-1:0] vram_d;
	logic                vram_wr;
	logic [`FONT_AW-1:0] fnt_a;
	logic [`FONT_DW-1:0] fnt_d;
	logic                fnt_wr;
	logic [3:0]          pixels;
	logic                pix_stb;
	logic                line_start;
	logic                int_start;

	// copies of the line memory and the font
	logic [`VRAM_DW-1:0] vmem [0:(1 << `VRAM_AW)-1];
	logic [`FONT_DW-1:0] fmem [0:(1 << `FONT_AW)-1];
	logic [31:0]         rnd;

	logic                check_req = 1'b0; // stimulus wants checking from next frame
	logic                check_en  = 1'b0;
	logic                seen_int  = 1'b0;
	logic                lp_valid  = 1'b0;
	logic                sym_valid = 1'b0; // glyph row known to the model
	logic [4:0]          frame_cnt = '0;   // flash level is bit 4
	logic [4:0]          mline     = '0;
	logic [`VRAM_AW-1:0] next_word = '0;
	logic [`VRAM_AW-1:0] cur_word  = '0;
	logic [`FONT_AW-1:0] sym_addr  = '0;
	int                  lp        = 0;    // pix_stb pulses in this line
	int                  mp        = 0;
	int                  mg        = 0;

	tb_clock tb_clock_inst
	(
		.clk    (clk),
		.arst_n (arst_n)
	);

	video_top video_top_inst
	(
		.clk        (clk),
		.arst_n     (arst_n),
		.mode       (mode),
		.pixf_14    (pixf_14),
		.vram_a     (vram_a),
		.vram_d     (vram_d),
		.vram_wr    (vram_wr),
		.fnt_a      (fnt_a),
		.fnt_d      (fnt_d),
		.fnt_wr     (fnt_wr),
		.pixels     (pixels),
		.pix_stb    (pix_stb),
		.line_start (line_start),
		.int_start  (int_start)
	);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic is_16c(input video_mode_e m);
		return (m == mode_p_16c) || (m == mode_a_16c);
	endfunction

	function automatic logic is_zxattr(input video_mode_e m);
		return (m == mode_zx) || (m == mode_p_hmclr);
	endfunction

	// interleave: group bit 0 picks the word half, attribute sits two bytes up
	function automatic int pix_byte_idx(input int g);
		return (g % 2) * 4 + g / 2;
	endfunction

	function automatic logic [7:0] byte_of(input logic [63:0] w, input int idx);
		return 8'(w >> (8 * idx));
	endfunction

	function automatic logic [3:0] expect_pixel(input video_mode_e m, input logic [63:0] w,
		input int p, input int g, input logic fl, input logic [7:0] sym);
		logic [7:0] pb;
		logic [7:0] ab;
		logic [7:0] b;
		logic [2:0] bi;
		logic       bit_v;
		pb = byte_of(w, pix_byte_idx(g));
		ab = byte_of(w, pix_byte_idx(g) + 2);
		bi = 3'(7 - p); // msb is the leftmost pixel
		if (is_16c(m))
		begin
			b = (p >= 4) ? pb : ab;
			return ((p & 2) != 0) ? {b[7], b[5:3]} : {b[6], b[2:0]};
		end
		bit_v = (m == mode_a_text) ? sym[bi] : pb[bi];
		if (is_zxattr(m) && fl && ab[7])
			bit_v = ~bit_v;
		if (bit_v)
			return {ab[6], ab[2:0]};
		return {is_zxattr(m) ? ab[6] : ab[7], ab[5:3]};
	endfunction

	task automatic halt_sim();
		$display("Test failures found");
		$fatal(1, "simulation stopped at the first failure");
	endtask

	task automatic fail_plain(input string what);
		$display("%s", what);
		halt_sim();
	endtask

	task automatic report_value(input string name, input int expv, input int gotv);
		$display("ERR %0t %s expected %0h got %0h", $time, name, expv, gotv);
		halt_sim();
	endtask

	task automatic wait_int_start();
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				fail_plain("timeout while waiting for the frame interrupt");
		end
		while (!int_start);
	endtask

	task automatic wait_vblank();
		int n;
		n = 0;
		do
		begin
			@(negedge clk);
			n++;
			if (n > WAIT_LIMIT)
				fail_plain("timeout while waiting for vertical blanking");
		end
		while (video_top_inst.video_sync_inst.state != st_vblank);
	endtask

	task automatic load_vram();
		logic [31:0] hi;
		logic [63:0] word;
		for (int a = 0; a < (1 << `VRAM_AW); a++)
		begin
			rnd = lcg_next(rnd);
			hi = rnd;
			rnd = lcg_next(rnd);
			word = {hi, rnd};
			@(negedge clk);
			vram_a = `VRAM_AW'(a);
			vram_d = word;
			vram_wr = 1'b1;
			vmem[`VRAM_AW'(a)] = word;
		end
		@(negedge clk);
		vram_wr = 1'b0;
	endtask

	task automatic load_font();
		for (int a = 0; a < (1 << `FONT_AW); a++)
		begin
			rnd = lcg_next(rnd);
			@(negedge clk);
			fnt_a = `FONT_AW'(a);
			fnt_d = rnd[23:16]; // upper bits of the lcg are the better ones
			fnt_wr = 1'b1;
			fmem[`FONT_AW'(a)] = rnd[23:16];
		end
		@(negedge clk);
		fnt_wr = 1'b0;
	endtask

	// switch mode in blanking, then check n whole frames
	task automatic run_mode(input video_mode_e m, input logic pf, input int n);
		check_req = 1'b0;
		wait_vblank();
		mode = m;
		pixf_14 = pf;
		check_req = 1'b1;
		repeat (n) wait_int_start();
		wait_vblank();
	endtask

	// invert the glyph of the first symbol code in the line memory
	task automatic rewrite_glyph();
		logic [7:0]          code;
		logic [`FONT_AW-1:0] addr;
		code = byte_of(vmem[0], 0);
		for (int r = 0; r < 8; r++)
		begin
			addr = {code, 3'(r)};
			@(negedge clk);
			fnt_a = addr;
			fnt_d = ~fmem[addr];
			fnt_wr = 1'b1;
			fmem[addr] = ~fmem[addr];
		end
		@(negedge clk);
		fnt_wr = 1'b0;
	endtask

	always @(posedge clk)
	begin : model_step
		logic [3:0] exp_pix;
		logic [7:0] pb;
		int         blk;
		if (arst_n)
		begin
			if (!seen_int && !int_start)
				assert (!(video_top_inst.video_sync_inst.c0 | video_top_inst.video_sync_inst.c1 |
					video_top_inst.video_sync_inst.c2 | video_top_inst.video_sync_inst.c3 |
					pix_stb | line_start))
				else
					fail_plain("a strobe was high before the first frame interrupt");
			assert ($onehot0({video_top_inst.video_sync_inst.c3, video_top_inst.video_sync_inst.c2,
				video_top_inst.video_sync_inst.c1, video_top_inst.video_sync_inst.c0}))
			else
				fail_plain("phase strobes c0 to c3 are not one-hot");
			if (!check_req)
				check_en = 1'b0;
			if (line_start)
			begin
				if (lp_valid)
					assert (lp == `LINE_PIXELS)
					else
						report_value("pix_stb per line", `LINE_PIXELS, lp);
				lp = 0;
				lp_valid = 1'b1;
				mline = int_start ? 5'd0 : mline + 5'd1;
			end
			if (int_start)
			begin
				seen_int = 1'b1;
				next_word = '0;
				frame_cnt = frame_cnt + 5'd1;
				sym_valid = 1'b0; // rows read in blanking are not tracked
				check_en = check_req;
			end
			if (pix_stb)
			begin
				blk = (is_16c(mode) || mode == mode_zx) ? 16 : 32;
				if (lp % blk == 0)
				begin
					cur_word = next_word;
					next_word = next_word + 1'b1;
					mp = 0;
					mg = 0;
				end
				exp_pix = expect_pixel(mode, vmem[cur_word], mp, mg, frame_cnt[4], fmem[sym_addr]);
				if (check_en && (mode != mode_a_text || sym_valid))
					assert (pixels === exp_pix)
					else
						report_value("pixels", int'(exp_pix), int'(pixels));
				mp = mp + (is_16c(mode) ? 2 : 1);
				if (mp >= 8)
				begin
					mp = mp - 8;
					pb = byte_of(vmem[cur_word], pix_byte_idx(mg));
					sym_addr = {pb, mline[2:0]}; // glyph row for the next group
					sym_valid = 1'b1;
					mg = (mg + (is_zxattr(mode) ? 2 : 1)) % 4;
				end
				lp++;
			end
		end
	end

	initial
	begin : stimulus
		int n;
		mode = mode_zx;
		pixf_14 = 1'b0;
		vram_a = '0;
		vram_d = '0;
		vram_wr = 1'b0;
		fnt_a = '0;
		fnt_d = '0;
		fnt_wr = 1'b0;
		rnd = 32'd15;
		n = 0;
		while (!arst_n)
		begin
			@(negedge clk);
			n++;
			if (n > 20)
				fail_plain("reset was never released");
		end
		load_vram();
		load_font();
		run_mode(mode_zx, 1'b0, 2);
		run_mode(mode_zx, 1'b1, 32); // fast pixel rate, flash toggles twice
		run_mode(mode_p_hmclr, 1'b0, 3);
		run_mode(mode_p_16c, 1'b1, 2);
		run_mode(mode_a_16c, 1'b0, 2);
		run_mode(mode_a_hmclr, 1'b1, 2);
		run_mode(mode_a_text, 1'b0, 2);
		rewrite_glyph();
		repeat (2) wait_int_start();
		wait_vblank();
		$display("All tests passed!");
		$finish;
	end

endmodule

// File: src.f
+incdir+src
src/video_pkg.sv
src/video_sync.sv
src/video_fetch.sv
src/video_fontrom.sv
src/video_render.sv
src/video_top.sv
tests/tb_clock.sv
tests/video_tb.sv

// File: run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -f src.f --top-module video_tb -o video_sim

# the simulator exit status is masked by tee, the log decides
./obj_dir/video_sim | tee sim.log

if grep -q 'All tests passed!' sim.log; then
	echo "simulation passed"
else
	echo "simulation failed"
	exit 1
fi
